//--- source/qracc_macros.svh
// Build-time sizes only; ACC_BITS must stay ADC_BITS + INPUT_BITS + 1 and INPUT_BITS must be >= 2
`ifndef QRACC_MACROS_SVH
`define QRACC_MACROS_SVH

// Array geometry
`define N_ROWS 32
`define N_COLS 8

// Signed two's complement width of each input lane
`define INPUT_BITS 4

// Modelled ADC: signed code width and the arithmetic shift from column sum to code
`define ADC_BITS 4
`define ADC_SHIFT 2

// Signed width of each rounded output element
`define OUTPUT_BITS 4

// Shift-accumulator width
// Holds INPUT_BITS weighted ADC codes plus one bit of growth
`define ACC_BITS (`ADC_BITS + `INPUT_BITS + 1)

`endif

//--- source/qracc_pkg.sv
// Types shared by controller and array; all sizes are fixed by the macro header at build time
`include "qracc_macros.svh"

package qracc_pkg;

    // Row index into the weight memory
    typedef logic [$clog2(`N_ROWS)-1:0] row_addr_t;

    // One signed ADC code, elements of a packed array of this stay signed
    typedef logic signed [`ADC_BITS-1:0] adc_code_t;

    // Everything the controller drives into the array
    typedef struct packed {
        // Bipolar row drive, at most one of p or n per row
        logic [`N_ROWS-1:0] data_p;
        logic [`N_ROWS-1:0] data_n;
        logic               mac_en;
        // Weight write port
        logic               wr_en;
        row_addr_t          wr_addr;
        logic [`N_COLS-1:0] wr_data;
    } to_analog_t;

    // Registered response of the array
    typedef struct packed {
        logic                         adc_valid;
        adc_code_t [`N_COLS-1:0]      adc_out;
    } from_analog_t;

    // Weight write request from outside, one bit per column
    typedef struct packed {
        logic               en;
        row_addr_t          addr;
        logic [`N_COLS-1:0] data;
    } wr_req_t;

    // Sequencer FSM
    typedef enum logic [1:0] {
        S_IDLE,
        S_BITS,
        S_DRAIN
    } seq_state_e;

endpackage

//--- source/twos_to_bipolar.sv
// Purely combinational; a clear bit drives neither rail, so p and n are never both set in a row
`include "qracc_macros.svh"

module twos_to_bipolar (
    input  logic [`N_ROWS-1:0] plane_i,
    input  logic               sign_plane_i,
    output logic [`N_ROWS-1:0] data_p_o,
    output logic [`N_ROWS-1:0] data_n_o
);

    // Sign plane of a two's complement number carries weight -2^(n-1)
    // so its set bits go to the negative rail
    always_comb begin
        for (int r = 0; r < `N_ROWS; r++) begin
            if (sign_plane_i) begin
                data_p_o[r] = 1'b0;
                data_n_o[r] = plane_i[r];
            end else begin
                data_p_o[r] = plane_i[r];
                data_n_o[r] = 1'b0;
            end
        end
    end

endmodule

//--- source/qr_acc_array.sv
// Digital stand-in for the analog array; one cycle MAC latency, weights reset to all -1
`include "qracc_macros.svh"

module qr_acc_array import qracc_pkg::*; (
    input  logic         clk,
    input  logic         nrst,
    input  to_analog_t   to_analog_i,
    output from_analog_t from_analog_o
);

    // Column sum spans -N_ROWS..+N_ROWS
    localparam int SUM_BITS = $clog2(`N_ROWS) + 2;

    localparam logic signed [SUM_BITS-1:0] SUM_ONE = 1;
    localparam logic signed [SUM_BITS-1:0] ADC_MAX = 2 ** (`ADC_BITS - 1) - 1;
    localparam logic signed [SUM_BITS-1:0] ADC_MIN = -(2 ** (`ADC_BITS - 1));

    // Weight bit 1 is +1, bit 0 is -1
    logic [`N_ROWS-1:0][`N_COLS-1:0] weights_q;

    logic signed [SUM_BITS-1:0] col_sum [`N_COLS];
    logic signed [SUM_BITS-1:0] col_shifted [`N_COLS];

    adc_code_t [`N_COLS-1:0] adc_d;
    adc_code_t [`N_COLS-1:0] adc_q;
    logic                    adc_valid_q;

    // Weight memory, a write lands on its own edge
    always_ff @(posedge clk) begin
        if (!nrst) begin
            weights_q <= '0;
        end else if (to_analog_i.wr_en) begin
            weights_q[to_analog_i.wr_addr] <= to_analog_i.wr_data;
        end
    end

    // Bitline sums
    // Each driven row adds (p - n) * w with w in {+1, -1}
    always_comb begin
        for (int c = 0; c < `N_COLS; c++) begin
            col_sum[c] = '0;
            for (int r = 0; r < `N_ROWS; r++) begin
                if (to_analog_i.data_p[r]) begin
                    if (weights_q[r][c]) begin
                        col_sum[c] = col_sum[c] + SUM_ONE;
                    end else begin
                        col_sum[c] = col_sum[c] - SUM_ONE;
                    end
                end
                if (to_analog_i.data_n[r]) begin
                    if (weights_q[r][c]) begin
                        col_sum[c] = col_sum[c] - SUM_ONE;
                    end else begin
                        col_sum[c] = col_sum[c] + SUM_ONE;
                    end
                end
            end
        end
    end

    // ADC model
    // Arithmetic shift floors toward minus infinity, then clip to the code range
    always_comb begin
        for (int c = 0; c < `N_COLS; c++) begin
            col_shifted[c] = col_sum[c] >>> `ADC_SHIFT;
            if (col_shifted[c] > ADC_MAX) begin
                adc_d[c] = ADC_MAX[`ADC_BITS-1:0];
            end else if (col_shifted[c] < ADC_MIN) begin
                adc_d[c] = ADC_MIN[`ADC_BITS-1:0];
            end else begin
                adc_d[c] = col_shifted[c][`ADC_BITS-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            adc_valid_q <= 1'b0;
        end else begin
            adc_valid_q <= to_analog_i.mac_en;
        end
    end

    // Codes only move on a conversion
    always_ff @(posedge clk) begin
        if (to_analog_i.mac_en) begin
            adc_q <= adc_d;
        end
    end

    always_comb begin
        from_analog_o.adc_valid = adc_valid_q;
        from_analog_o.adc_out   = adc_q;
    end

endmodule

//--- source/seq_acc.sv
// One job in flight; ready_o drops for the whole job, weight writes while busy are dropped
`include "qracc_macros.svh"

module seq_acc import qracc_pkg::*; (
    input  logic                                      clk,
    input  logic                                      nrst,
    input  logic [`N_ROWS-1:0][`INPUT_BITS-1:0]       mac_data_i,
    input  logic                                      mac_valid_i,
    output logic                                      ready_o,
    input  wr_req_t                                   wr_i,
    output logic                                      valid_o,
    output logic [`N_COLS-1:0][`OUTPUT_BITS-1:0]      mac_data_o,
    output to_analog_t                                to_analog_o,
    input  from_analog_t                              from_analog_i
);

    localparam int CNT_BITS = $clog2(`INPUT_BITS);
    localparam logic [CNT_BITS-1:0] LAST_PLANE = CNT_BITS'(`INPUT_BITS - 1);

    seq_state_e state_q;
    seq_state_e state_d;

    logic [`N_ROWS-1:0][`INPUT_BITS-1:0]  piso_q;
    logic [CNT_BITS-1:0]                  plane_cnt_q;
    logic [`N_COLS-1:0][`ACC_BITS-1:0]    acc_q;
    logic [`N_COLS-1:0][`OUTPUT_BITS-1:0] rounded;

    logic [`N_ROWS-1:0] plane;
    logic [`N_ROWS-1:0] data_p;
    logic [`N_ROWS-1:0] data_n;
    logic               sign_plane;
    logic               mac_en;
    logic               accept;
    logic               last_plane;
    logic               finish;

    // Top OUTPUT_BITS rounded up on any discarded bit, positive overflow clips
    function automatic logic [`OUTPUT_BITS-1:0] round_sat(input logic [`ACC_BITS-1:0] acc);
        logic [`OUTPUT_BITS:0] sum;
        logic                  round_up;
        round_up = |acc[`ACC_BITS-`OUTPUT_BITS-1:0];
        sum = {acc[`ACC_BITS-1], acc[`ACC_BITS-1 -: `OUTPUT_BITS]}
            + (`OUTPUT_BITS + 1)'(round_up);
        // Adding one can only overflow upward
        if (sum[`OUTPUT_BITS] != sum[`OUTPUT_BITS-1]) begin
            return {1'b0, {(`OUTPUT_BITS - 1){1'b1}}};
        end
        return sum[`OUTPUT_BITS-1:0];
    endfunction

    assign ready_o    = (state_q == S_IDLE);
    assign accept     = mac_valid_i && ready_o;
    assign mac_en     = (state_q == S_BITS);
    assign last_plane = (plane_cnt_q == LAST_PLANE);
    assign sign_plane = (plane_cnt_q == '0);

    // Last code went into the accumulator on the previous edge
    assign finish = (state_q == S_DRAIN) && !from_analog_i.adc_valid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (accept) begin
                    state_d = S_BITS;
                end
            end
            S_BITS: begin
                if (last_plane) begin
                    state_d = S_DRAIN;
                end
            end
            S_DRAIN: begin
                if (finish) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state_q     <= S_IDLE;
            plane_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (accept || last_plane) begin
                plane_cnt_q <= '0;
            end else if (mac_en) begin
                plane_cnt_q <= plane_cnt_q + CNT_BITS'(1);
            end
        end
    end

    // PISO buffer, MSB plane sits at the top bit of every lane
    always_ff @(posedge clk) begin
        if (accept) begin
            piso_q <= mac_data_i;
        end else if (mac_en) begin
            for (int r = 0; r < `N_ROWS; r++) begin
                piso_q[r] <= {piso_q[r][`INPUT_BITS-2:0], 1'b0};
            end
        end
    end

    always_comb begin
        for (int r = 0; r < `N_ROWS; r++) begin
            plane[r] = piso_q[r][`INPUT_BITS-1];
        end
    end

    twos_to_bipolar u_twos_to_bipolar (
        .plane_i      (plane),
        .sign_plane_i (sign_plane),
        .data_p_o     (data_p),
        .data_n_o     (data_n)
    );

    always_comb begin
        to_analog_o.data_p  = data_p;
        to_analog_o.data_n  = data_n;
        to_analog_o.mac_en  = mac_en;
        to_analog_o.wr_en   = wr_i.en && ready_o;
        to_analog_o.wr_addr = wr_i.addr;
        to_analog_o.wr_data = wr_i.data;
    end

    // Shift-accumulate, MSB plane arrives first so doubling gives it the top weight
    always_ff @(posedge clk) begin
        if (accept) begin
            acc_q <= '0;
        end else if (from_analog_i.adc_valid) begin
            for (int c = 0; c < `N_COLS; c++) begin
                acc_q[c] <= {acc_q[c][`ACC_BITS-2:0], 1'b0}
                          + `ACC_BITS'(signed'(from_analog_i.adc_out[c]));
            end
        end
    end

    always_comb begin
        for (int c = 0; c < `N_COLS; c++) begin
            rounded[c] = round_sat(acc_q[c]);
        end
    end

    // Result holds until the next job finishes
    always_ff @(posedge clk) begin
        if (!nrst) begin
            valid_o    <= 1'b0;
            mac_data_o <= '0;
        end else begin
            valid_o <= finish;
            if (finish) begin
                mac_data_o <= rounded;
            end
        end
    end

endmodule

//--- source/qracc_top.sv
// Result appears 6 edges after acceptance; no output back-pressure, so valid_o must be taken at once
`include "qracc_macros.svh"

module qracc_top import qracc_pkg::*; (
    input  logic                                 clk,
    input  logic                                 nrst,
    // Job input
    input  logic [`N_ROWS-1:0][`INPUT_BITS-1:0]  mac_data_i,
    input  logic                                 mac_valid_i,
    output logic                                 ready_o,
    // Weight load, honoured only while idle
    input  wr_req_t                              wr_i,
    // Result
    output logic                                 valid_o,
    output logic [`N_COLS-1:0][`OUTPUT_BITS-1:0] mac_data_o
);

    to_analog_t   to_analog;
    from_analog_t from_analog;

    seq_acc u_seq_acc (
        .clk           (clk),
        .nrst          (nrst),
        .mac_data_i    (mac_data_i),
        .mac_valid_i   (mac_valid_i),
        .ready_o       (ready_o),
        .wr_i          (wr_i),
        .valid_o       (valid_o),
        .mac_data_o    (mac_data_o),
        .to_analog_o   (to_analog),
        .from_analog_i (from_analog)
    );

    // Compute-in-memory array model
    qr_acc_array u_qr_acc_array (
        .clk           (clk),
        .nrst          (nrst),
        .to_analog_i   (to_analog),
        .from_analog_o (from_analog)
    );

endmodule

//--- dv/tb_qracc.sv
// Expects the default macro sizes and a 6-edge job latency; the LFSR seed fixes all stimulus
`include "qracc_macros.svh"

module tb_qracc import qracc_pkg::*; ;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 40;
    localparam int LATENCY        = `INPUT_BITS + 2;
    localparam int ADC_MAX        = 2 ** (`ADC_BITS - 1) - 1;
    localparam int ADC_MIN        = -(2 ** (`ADC_BITS - 1));
    localparam int OUT_MAX        = 2 ** (`OUTPUT_BITS - 1) - 1;
    localparam int DROP_BITS      = `ACC_BITS - `OUTPUT_BITS;

    typedef logic [`N_ROWS-1:0][`INPUT_BITS-1:0]  vec_t;
    typedef logic [`N_COLS-1:0][`OUTPUT_BITS-1:0] res_t;

    logic    clk;
    logic    nrst;
    vec_t    mac_data_i;
    logic    mac_valid_i;
    logic    ready_o;
    wr_req_t wr_i;
    logic    valid_o;
    res_t    mac_data_o;

    // Reference copy of the weights with bit 1 meaning +1
    logic [`N_COLS-1:0] model_w [`N_ROWS];

    logic [31:0] lfsr;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_start_errors;
    logic        timed_out;

    qracc_top dut0 (
        .clk         (clk),
        .nrst        (nrst),
        .mac_data_i  (mac_data_i),
        .mac_valid_i (mac_valid_i),
        .ready_o     (ready_o),
        .wr_i        (wr_i),
        .valid_o     (valid_o),
        .mac_data_o  (mac_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // 32-bit Fibonacci LFSR with taps 32 22 2 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic vec_t rand_vec();
        vec_t        v;
        logic [31:0] lane;
        for (int r = 0; r < `N_ROWS; r++) begin
            lane = rand_bits(`INPUT_BITS);
            v[r] = lane[`INPUT_BITS-1:0];
        end
        return v;
    endfunction

    function automatic vec_t fill_vec(input logic [`INPUT_BITS-1:0] lane);
        vec_t v;
        for (int r = 0; r < `N_ROWS; r++) begin
            v[r] = lane;
        end
        return v;
    endfunction

    // Bit-serial MAC reference with planes taken MSB first
    function automatic res_t model_mac(input vec_t data);
        res_t res;
        int   sum;
        int   code;
        int   acc;
        int   drive;
        int   q;
        for (int c = 0; c < `N_COLS; c++) begin
            acc = 0;
            for (int p = 0; p < `INPUT_BITS; p++) begin
                sum = 0;
                for (int r = 0; r < `N_ROWS; r++) begin
                    if (data[r][`INPUT_BITS-1-p]) begin
                        // Sign plane drives the negative rail
                        drive = (p == 0) ? -1 : 1;
                        sum += model_w[r][c] ? drive : -drive;
                    end
                end
                // Floor then clip to the ADC range
                code = sum >>> `ADC_SHIFT;
                if (code > ADC_MAX) begin
                    code = ADC_MAX;
                end else if (code < ADC_MIN) begin
                    code = ADC_MIN;
                end
                acc = 2 * acc + code;
            end
            // Keep the top bits and round up on any dropped bit
            q = acc >>> DROP_BITS;
            if ((acc & ((1 << DROP_BITS) - 1)) != 0) begin
                q++;
            end
            if (q > OUT_MAX) begin
                q = OUT_MAX;
            end
            res[c] = q[`OUTPUT_BITS-1:0];
        end
        return res;
    endfunction

    // Parks the main sequence so the watchdog ends the run
    task automatic stall_after_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
        timed_out = 1'b1;
        forever @(negedge clk);
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!ready_o && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!ready_o) begin
            stall_after_timeout("ready_o");
        end
    endtask

    task automatic write_weight(input int row, input logic [`N_COLS-1:0] data);
        wait_ready();
        wr_i.en   = 1'b1;
        wr_i.addr = row_addr_t'(row);
        wr_i.data = data;
        @(negedge clk);
        wr_i = '0;
        model_w[row] = data;
    endtask

    // One job from acceptance to result with latency and ready_o checked on the way
    task automatic run_job(input vec_t data, input logic busy_write, input wr_req_t busy_wr);
        res_t want;
        int   edges;
        want = model_mac(data);
        wait_ready();
        mac_valid_i = 1'b1;
        mac_data_i  = data;
        @(negedge clk);
        mac_valid_i = 1'b0;
        edges = 0;
        while (!valid_o && edges < TIMEOUT_CYCLES) begin
            assert (!ready_o) else begin
                $display("MISMATCH %0t: ready_o high %0d edges after acceptance", $time, edges);
                errors++;
            end
            // Weight write in the middle of the job
            if (busy_write && edges == 1) begin
                wr_i = busy_wr;
            end else begin
                wr_i = '0;
            end
            @(negedge clk);
            edges++;
        end
        if (!valid_o) begin
            stall_after_timeout("valid_o");
        end
        assert (edges == LATENCY) else begin
            $display("MISMATCH %0t: valid_o after %0d edges, expected %0d", $time, edges, LATENCY);
            errors++;
        end
        assert (ready_o) else begin
            $display("MISMATCH %0t: ready_o low in the valid_o cycle", $time);
            errors++;
        end
        for (int c = 0; c < `N_COLS; c++) begin
            assert (mac_data_o[c] == want[c]) else begin
                $display("MISMATCH %0t: column %0d got %0d expected %0d", $time, c,
                         $signed(mac_data_o[c]), $signed(want[c]));
                errors++;
            end
        end
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    initial begin
        wait (timed_out);
        $display("Tests run %0d, failed %0d, errors %0d, stopped by timeout",
                 tests_run, tests_failed, errors);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        res_t        held;
        wr_req_t     no_write;
        wr_req_t     stray;
        vec_t        data;
        logic [31:0] w;
        lfsr              = 32'hbd58;
        errors            = 0;
        tests_run         = 0;
        tests_failed      = 0;
        test_start_errors = 0;
        timed_out         = 1'b0;
        nrst              = 1'b0;
        mac_valid_i       = 1'b0;
        mac_data_i        = '0;
        wr_i              = '0;
        no_write          = '0;
        for (int r = 0; r < `N_ROWS; r++) begin
            model_w[r] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;

        // Reset state with the default all -1 weights
        assert (ready_o && !valid_o && mac_data_o == '0) else begin
            $display("MISMATCH %0t: after reset ready_o=%b valid_o=%b mac_data_o=%h",
                     $time, ready_o, valid_o, mac_data_o);
            errors++;
        end
        run_job('0, 1'b0, no_write);
        close_test("reset_state");

        for (int r = 0; r < `N_ROWS; r++) begin
            w = rand_bits(`N_COLS);
            write_weight(r, w[`N_COLS-1:0]);
        end
        for (int j = 0; j < 40; j++) begin
            run_job(rand_vec(), 1'b0, no_write);
        end
        close_test("random_mac");

        // All +1 weights with the most negative input and then the saturating +1 input
        for (int r = 0; r < `N_ROWS; r++) begin
            write_weight(r, '1);
        end
        run_job(fill_vec({1'b1, {(`INPUT_BITS-1){1'b0}}}), 1'b0, no_write);
        run_job(fill_vec({{(`INPUT_BITS-1){1'b0}}, 1'b1}), 1'b0, no_write);
        close_test("sign_saturation");

        // Back-to-back jobs each taken on the edge that ends valid_o
        for (int j = 0; j < 5; j++) begin
            run_job(rand_vec(), 1'b0, no_write);
        end
        held = mac_data_o;
        @(negedge clk);
        assert (!valid_o && mac_data_o == held) else begin
            $display("MISMATCH %0t: valid_o=%b mac_data_o=%h after the result cycle",
                     $time, valid_o, mac_data_o);
            errors++;
        end
        close_test("exact_timing");

        // Row 0 flip would change the next result if the write were taken
        stray.en   = 1'b1;
        stray.addr = '0;
        stray.data = ~model_w[0];
        run_job(rand_vec(), 1'b1, stray);
        data = '0;
        for (int r = 0; r < 4; r++) begin
            data[r] = {1'b0, {(`INPUT_BITS-1){1'b1}}};
        end
        run_job(data, 1'b0, no_write);
        close_test("write_while_busy");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+source
source/qracc_pkg.sv
source/twos_to_bipolar.sv
source/qr_acc_array.sv
source/seq_acc.sv
source/qracc_top.sv
dv/tb_qracc.sv

//--- Makefile
# Verilator flow for the compute-in-memory MAC accelerator
# Override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR  ?= verilator
FILELIST   ?= build.f
TB_TOP     ?= tb_qracc
RTL_TOP    ?= qracc_top
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/1ps
LINT_FLAGS ?= --lint-only -Wall --timing --timescale $(TIMESCALE)
SIM_FLAGS  ?= --binary --timing --assert --timescale $(TIMESCALE)
PASS_MSG   ?= Finished with no errors

SIM_BIN = $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(FILELIST) $(wildcard source/*.sv source/*.svh dv/*.sv)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR) -o V$(TB_TOP)

# Pass only if the testbench printed the pass message on a line of its own
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
